// ==== filelist.f ====
+incdir+verif
verilog/conv_pkg.sv
verilog/coeff_rotator.sv
verilog/tap_mac.sv
verilog/conv_controller.sv
verilog/conv_unit.sv
verif/conv_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the conv_unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module conv_unit_tb -Mdir obj_dir \
    && ./obj_dir/Vconv_unit_tb > sim.log 2>&1 \
    || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1

// ==== verif/conv_ref.svh ====
`ifndef CONV_REF_SVH
`define CONV_REF_SVH

// window offset of tap k: row step dy, column step dx
function automatic int ref_shift(input int k);
    int dy;
    int dx;
    dy = k / 2;
    dx = k % 2;
    return dy * IMG_W + dx;
endfunction

// coefficient i of poly * X^-s in Z_Q[X]/(X^N + 1)
function automatic int rotated_coeff(input int poly [N], input int i, input int s);
    int j;
    int v;
    j = i + s;
    if (j < N) begin
        return poly[j];
    end
    v = poly[j - N];  // wrapped part picks up a minus sign
    return (v == 0) ? 0 : Q - v;
endfunction

// sum over taps of weight times rotated coefficient, mod Q
function automatic int conv_expected(input int poly [N], input int weights [NUM_TAPS],
                                     input int i);
    longint acc;
    int     k;
    acc = 0;
    for (k = 0; k < NUM_TAPS; k++) begin
        acc = acc + longint'(weights[k]) * longint'(rotated_coeff(poly, i, ref_shift(k)));
    end
    return int'(acc % longint'(Q));
endfunction

`endif

// ==== verif/conv_unit_tb.sv ====
`timescale 1ns/100ps

module conv_unit_tb;
    import conv_pkg::*;

    localparam int N          = 256;
    localparam int IMG_W      = 16;
    localparam int TIMEOUT    = 40 * N;
    localparam int PAT_RANDOM = 0;
    localparam int PAT_MAX    = 1;
    localparam int PAT_RAMP   = 2;
    localparam int RAND_W     = -1;
    localparam int NUM_ROWS   = 8;

    typedef struct packed {
        int w0;
        int w1;
        int w2;
        int w3;
        int pat;
        int gap_pct;
        int stall_pct;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{1, 0, 0, 0, PAT_RAMP, 0, 0},        // identity
        '{0, 1, 0, 0, PAT_RAMP, 0, 0},        // shift by one with wrap at the end
        '{0, 0, 0, 1, PAT_RAMP, 0, 0},        // shift by IMG_W+1
        '{0, 0, 1, 0, PAT_RANDOM, 20, 20},
        '{RAND_W, RAND_W, RAND_W, RAND_W, PAT_RANDOM, 0, 0},
        '{Q-1, Q-1, Q-1, Q-1, PAT_MAX, 0, 0}, // largest products
        '{RAND_W, RAND_W, RAND_W, RAND_W, PAT_RANDOM, 30, 50},
        '{RAND_W, RAND_W, RAND_W, RAND_W, PAT_RAMP, 60, 70}
    };

    logic   clk;
    logic   reset;
    logic   start;
    coeff_t weight_0;
    coeff_t weight_1;
    coeff_t weight_2;
    coeff_t weight_3;
    logic   in_valid;
    logic   in_ready;
    coeff_t in_c0;
    coeff_t in_c1;
    logic   out_valid;
    logic   out_ready;
    coeff_t out_c0;
    coeff_t out_c1;
    logic   done;

    int src_c0 [N];
    int src_c1 [N];
    int got_c0 [N];
    int got_c1 [N];
    int wt [NUM_TAPS];
    int checks;
    int errors;
    int n_in;
    int n_out;
    bit timed_out;

    `include "conv_ref.svh"

    conv_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_input(input int gap_pct);
        int waited;
        n_in = 0;
        waited = 0;
        while (n_in < N && waited < TIMEOUT) begin
            if (int'($urandom % 100) < gap_pct) begin
                in_valid = 1'b0;
            end else begin
                in_valid = 1'b1;
                in_c0 = coeff_t'(src_c0[n_in]);
                in_c1 = coeff_t'(src_c1[n_in]);
            end
            if (in_valid && in_ready) n_in++;  // taken on the coming rising edge
            @(negedge clk);
            waited++;
        end
        in_valid = 1'b0;
        if (n_in < N) begin
            timed_out = 1'b1;
            $display("ERROR at %0t: timeout, only %0d of %0d inputs accepted", $time, n_in, N);
        end
    endtask

    task automatic collect_output(input int stall_pct);
        int     waited;
        logic   held;
        coeff_t held_c0;
        coeff_t held_c1;
        n_out = 0;
        waited = 0;
        held = 1'b0;
        while (n_out < N && waited < TIMEOUT) begin
            check_value(int'(done), 0, "done before last output");
            if (held) begin  // stalled result must not move
                check_value(int'(out_valid), 1, "out_valid under stall");
                check_value(int'(out_c0), int'(held_c0), "out_c0 under stall");
                check_value(int'(out_c1), int'(held_c1), "out_c1 under stall");
            end
            out_ready = (int'($urandom % 100) >= stall_pct);
            held = out_valid && !out_ready;
            held_c0 = out_c0;
            held_c1 = out_c1;
            if (out_valid && out_ready) begin
                got_c0[n_out] = int'(out_c0);
                got_c1[n_out] = int'(out_c1);
                n_out++;
            end
            @(negedge clk);
            waited++;
        end
        out_ready = 1'b0;
        if (n_out < N) begin
            timed_out = 1'b1;
            $display("ERROR at %0t: timeout, only %0d of %0d results received", $time, n_out, N);
        end else begin
            check_value(int'(done), 1, "done after last output");
            check_value(int'(out_valid), 0, "extra output after last");
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   i;
        row = ROWS[r];
        wt[0] = (row.w0 == RAND_W) ? int'($urandom % Q) : row.w0;
        wt[1] = (row.w1 == RAND_W) ? int'($urandom % Q) : row.w1;
        wt[2] = (row.w2 == RAND_W) ? int'($urandom % Q) : row.w2;
        wt[3] = (row.w3 == RAND_W) ? int'($urandom % Q) : row.w3;
        for (i = 0; i < N; i++) begin
            case (row.pat)
                PAT_RAMP: begin
                    src_c0[i] = i;
                    src_c1[i] = Q - 1 - i;
                end
                PAT_MAX: begin
                    src_c0[i] = Q - 1;
                    src_c1[i] = Q - 1;
                end
                default: begin
                    src_c0[i] = int'($urandom % Q);
                    src_c1[i] = int'($urandom % Q);
                end
            endcase
        end
        if (r > 0) begin  // previous run still signalling done
            @(negedge clk);
            check_value(int'(done), 1, "done held until start");
        end
        weight_0 = coeff_t'(wt[0]);
        weight_1 = coeff_t'(wt[1]);
        weight_2 = coeff_t'(wt[2]);
        weight_3 = coeff_t'(wt[3]);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // weights only count when start is seen
        weight_0 = coeff_t'((wt[0] + 1) % Q);
        weight_1 = coeff_t'((wt[1] + 1) % Q);
        weight_2 = coeff_t'((wt[2] + 1) % Q);
        weight_3 = coeff_t'((wt[3] + 1) % Q);
        check_value(int'(done), 0, "done after start");
        check_value(int'(in_ready), 1, "in_ready after start");
        fork
            drive_input(row.gap_pct);
            collect_output(row.stall_pct);
        join
        if (timed_out) return;
        for (i = 0; i < N; i++) begin
            check_value(got_c0[i], conv_expected(src_c0, wt, i), $sformatf("c0[%0d]", i));
            check_value(got_c1[i], conv_expected(src_c1, wt, i), $sformatf("c1[%0d]", i));
        end
    endtask

    initial begin
        int r;
        int row_err;
        void'($urandom(32'h396c_5e37));
        reset = 1'b1;
        start = 1'b0;
        weight_0 = '0;
        weight_1 = '0;
        weight_2 = '0;
        weight_3 = '0;
        in_valid = 1'b0;
        in_c0 = '0;
        in_c1 = '0;
        out_ready = 1'b0;
        checks = 0;
        errors = 0;
        timed_out = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value(int'(in_ready), 0, "in_ready after reset");
        check_value(int'(out_valid), 0, "out_valid after reset");
        check_value(int'(done), 0, "done after reset");
        $display("reset: %0d errors", errors);
        for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
            row_err = errors;
            run_row(r);
            $display("row %0d: %0d results, %0d errors", r, n_out, errors - row_err);
        end
        $display("rows %0d, checks %0d, errors %0d", r, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/conv_unit.sv ====
`timescale 1ns/100ps

module conv_unit #(
    parameter int N     = 256,
    parameter int IMG_W = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  conv_pkg::coeff_t weight_0,
    input  conv_pkg::coeff_t weight_1,
    input  conv_pkg::coeff_t weight_2,
    input  conv_pkg::coeff_t weight_3,
    input  logic             in_valid,
    output logic             in_ready,
    input  conv_pkg::coeff_t in_c0,
    input  conv_pkg::coeff_t in_c1,
    output logic             out_valid,
    input  logic             out_ready,
    output conv_pkg::coeff_t out_c0,
    output conv_pkg::coeff_t out_c1,
    output logic             done
);
    import conv_pkg::*;

    localparam int AW = $clog2(N);

    logic                wr_en;
    logic [AW-1:0]       wr_addr;
    coeff_t              wr_c0;
    coeff_t              wr_c1;
    logic                issue_valid;
    logic [AW-1:0]       issue_index;
    logic                advance;
    logic                capture;
    coeff_t              tap_c0 [NUM_TAPS];
    coeff_t              tap_c1 [NUM_TAPS];
    logic [NUM_TAPS-1:0] tap_neg;
    logic                tap_valid;

    conv_controller #(
        .N(N)
    ) ctrl0 (
        .clk(clk),
        .reset(reset),
        .start(start),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_c0(in_c0),
        .in_c1(in_c1),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_c0(wr_c0),
        .wr_c1(wr_c1),
        .issue_valid(issue_valid),
        .issue_index(issue_index),
        .advance(advance),
        .capture(capture),
        .done(done)
    );

    coeff_rotator #(
        .N(N),
        .IMG_W(IMG_W)
    ) rot0 (
        .clk(clk),
        .reset(reset),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_c0(wr_c0),
        .wr_c1(wr_c1),
        .issue_valid(issue_valid),
        .issue_index(issue_index),
        .advance(advance),
        .tap_c0(tap_c0),
        .tap_c1(tap_c1),
        .tap_neg(tap_neg),
        .tap_valid(tap_valid)
    );

    tap_mac mac0 (
        .clk(clk),
        .reset(reset),
        .advance(advance),
        .capture(capture),
        .weight_0(weight_0),
        .weight_1(weight_1),
        .weight_2(weight_2),
        .weight_3(weight_3),
        .tap_c0(tap_c0),
        .tap_c1(tap_c1),
        .tap_neg(tap_neg),
        .tap_valid(tap_valid),
        .out_valid(out_valid),
        .out_c0(out_c0),
        .out_c1(out_c1)
    );

endmodule

// ==== verilog/conv_controller.sv ====
`timescale 1ns/100ps

module conv_controller #(
    parameter int N = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  conv_pkg::coeff_t     in_c0,
    input  conv_pkg::coeff_t     in_c1,
    input  logic                 out_valid,
    input  logic                 out_ready,
    output logic                 wr_en,
    output logic [$clog2(N)-1:0] wr_addr,
    output conv_pkg::coeff_t     wr_c0,
    output conv_pkg::coeff_t     wr_c1,
    output logic                 issue_valid,
    output logic [$clog2(N)-1:0] issue_index,
    output logic                 advance,
    output logic                 capture,
    output logic                 done
);

    localparam int AW = $clog2(N);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        COMPUTE,
        DONE
    } state_t;

    state_t        state;
    state_t        next_state;
    logic [AW-1:0] load_cnt;
    logic [AW:0]   issue_cnt;  // one extra bit to reach N
    logic [AW-1:0] out_cnt;
    logic          in_fire;
    logic          out_fire;
    logic          issue_fire;

    assign capture  = start && (state == IDLE || state == DONE);
    assign in_ready = (state == LOAD);
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;
    assign advance  = !(out_valid && !out_ready);  // whole pipe stalls together
    assign done     = (state == DONE);

    assign wr_en   = in_fire;
    assign wr_addr = load_cnt;
    assign wr_c0   = in_c0;
    assign wr_c1   = in_c1;

    assign issue_valid = (state == COMPUTE) && (issue_cnt < (AW+1)'(N));
    assign issue_fire  = issue_valid && advance;
    assign issue_index = issue_cnt[AW-1:0];

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) next_state = LOAD;
            end
            LOAD: begin
                if (in_fire && load_cnt == AW'(N - 1)) next_state = COMPUTE;
            end
            COMPUTE: begin
                if (out_fire && out_cnt == AW'(N - 1)) next_state = DONE;
            end
            DONE: begin
                if (start) next_state = LOAD;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_cnt  <= '0;
            issue_cnt <= '0;
            out_cnt   <= '0;
        end else if (capture) begin
            load_cnt  <= '0;
            issue_cnt <= '0;
            out_cnt   <= '0;
        end else begin
            if (in_fire) load_cnt <= load_cnt + 1'b1;
            if (issue_fire) issue_cnt <= issue_cnt + 1'b1;
            if (out_fire) out_cnt <= out_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/tap_mac.sv ====
`timescale 1ns/100ps

module tap_mac (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          advance,
    input  logic                          capture,
    input  conv_pkg::coeff_t              weight_0,
    input  conv_pkg::coeff_t              weight_1,
    input  conv_pkg::coeff_t              weight_2,
    input  conv_pkg::coeff_t              weight_3,
    input  conv_pkg::coeff_t              tap_c0 [conv_pkg::NUM_TAPS],
    input  conv_pkg::coeff_t              tap_c1 [conv_pkg::NUM_TAPS],
    input  logic [conv_pkg::NUM_TAPS-1:0] tap_neg,
    input  logic                          tap_valid,
    output logic                          out_valid,
    output conv_pkg::coeff_t              out_c0,
    output conv_pkg::coeff_t              out_c1
);
    import conv_pkg::*;

    // barrett constant for products below 2^RED_SHIFT
    localparam int          RED_SHIFT = 2 * COEFF_BITS;
    localparam logic [63:0] BARRETT_M = (64'd1 << RED_SHIFT) / 64'(Q);

    function automatic coeff_t cond_neg(coeff_t x, logic neg);
        if (neg && x != '0) begin
            return coeff_t'(Q - int'(x));
        end
        return x;
    endfunction

    function automatic coeff_t mod_mul(coeff_t a, coeff_t b);
        logic [63:0] x;
        logic [63:0] q_est;
        logic [63:0] r;
        x     = 64'(a) * 64'(b);
        q_est = (x * BARRETT_M) >> RED_SHIFT;  // low by at most one
        r     = x - q_est * 64'(Q);
        if (r >= 64'(Q)) begin
            r = r - 64'(Q);
        end
        return coeff_t'(r);
    endfunction

    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        logic [COEFF_BITS:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= (COEFF_BITS+1)'(Q)) begin
            s = s - (COEFF_BITS+1)'(Q);
        end
        return coeff_t'(s);
    endfunction

    coeff_t weight_q [NUM_TAPS];
    coeff_t prod_c0  [NUM_TAPS];
    coeff_t prod_c1  [NUM_TAPS];
    logic   prod_valid;
    coeff_t sum_c0;
    coeff_t sum_c1;

    always_ff @(posedge clk) begin
        if (capture) begin
            weight_q[0] <= weight_0;
            weight_q[1] <= weight_1;
            weight_q[2] <= weight_2;
            weight_q[3] <= weight_3;
        end
    end

    // stage one
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                prod_c0[k] <= mod_mul(cond_neg(tap_c0[k], tap_neg[k]), weight_q[k]);
                prod_c1[k] <= mod_mul(cond_neg(tap_c1[k], tap_neg[k]), weight_q[k]);
            end
        end
    end

    // two-level add tree
    assign sum_c0 = mod_add(mod_add(prod_c0[0], prod_c0[1]), mod_add(prod_c0[2], prod_c0[3]));
    assign sum_c1 = mod_add(mod_add(prod_c1[0], prod_c1[1]), mod_add(prod_c1[2], prod_c1[3]));

    always_ff @(posedge clk) begin
        if (advance) begin
            out_c0 <= sum_c0;
            out_c1 <= sum_c1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else if (advance) begin
            prod_valid <= tap_valid;
            out_valid  <= prod_valid;
        end
    end

endmodule

// ==== verilog/coeff_rotator.sv ====
`timescale 1ns/100ps

module coeff_rotator #(
    parameter int N     = 256,
    parameter int IMG_W = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [$clog2(N)-1:0]          wr_addr,
    input  conv_pkg::coeff_t              wr_c0,
    input  conv_pkg::coeff_t              wr_c1,
    input  logic                          issue_valid,
    input  logic [$clog2(N)-1:0]          issue_index,
    input  logic                          advance,
    output conv_pkg::coeff_t              tap_c0 [conv_pkg::NUM_TAPS],
    output conv_pkg::coeff_t              tap_c1 [conv_pkg::NUM_TAPS],
    output logic [conv_pkg::NUM_TAPS-1:0] tap_neg,
    output logic                          tap_valid
);
    import conv_pkg::*;

    localparam int AW = $clog2(N);

    logic [NUM_TAPS-1:0] wrap;

    // one store copy per read port, all written together
    for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
        localparam int SHIFT = tap_shift(k, IMG_W);

        coeff_t        mem_c0 [N];
        coeff_t        mem_c1 [N];
        logic [AW:0]   sum;
        logic [AW-1:0] rd_addr;

        assign sum     = {1'b0, issue_index} + (AW+1)'(SHIFT);
        assign rd_addr = sum[AW-1:0];  // mod N, N is a power of two
        assign wrap[k] = sum[AW];      // X^N = -1

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem_c0[wr_addr] <= wr_c0;
                mem_c1[wr_addr] <= wr_c1;
            end
            if (advance) begin
                tap_c0[k] <= mem_c0[rd_addr];
                tap_c1[k] <= mem_c1[rd_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tap_neg <= wrap;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tap_valid <= 1'b0;
        end else if (advance) begin
            tap_valid <= issue_valid;
        end
    end

endmodule

// ==== verilog/conv_pkg.sv ====
package conv_pkg;

    parameter int Q          = 12289;
    parameter int COEFF_BITS = 14;
    parameter int NUM_TAPS   = 4;

    typedef logic [COEFF_BITS-1:0] coeff_t;

    // 2x2 kernel on a row-major image: self, right, below, below-right
    function automatic int tap_shift(input int k, input int img_w);
        case (k)
            0: return 0;
            1: return 1;
            2: return img_w;
            default: return img_w + 1;
        endcase
    endfunction

endpackage
